// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = front_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Done: errors found

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the log decides, a crash or assertion stop also counts as failure
sim: build
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: filelist.f
verilog/front_pkg.sv
verilog/pc_gen.sv
verilog/branch_predictor.sv
verilog/inst_buffer.sv
verilog/front.sv
testbench/front_sva.sv
testbench/front_tb.sv

// File: testbench/front_sva.sv
`timescale 1ns/1ps
`default_nettype none

module front_sva
(
    input wire       cpu_clk,
    input wire       arst_n,
    input wire [1:0] fb_valid,
    input wire [1:0] fb_flush,
    input wire       bpu_flush,
    input wire       icache_inst_valid,
    input wire       fb_stall
);

    // second slot never valid alone
    valid_order: assert property (@(posedge cpu_clk) disable iff (!arst_n)
        fb_valid[1] |-> fb_valid[0])
        else $error("fb_valid[1] high while fb_valid[0] low");

    // buffer flush empties the queue
    flush_empties: assert property (@(posedge cpu_clk) disable iff (!arst_n)
        (fb_flush[1] || bpu_flush) |=> (fb_valid == 2'b00))
        else $error("fb_valid not cleared one cycle after flush");

    no_write_on_stall: assert property (@(posedge cpu_clk) disable iff (!arst_n)
        !(icache_inst_valid && fb_stall))
        else $error("icache_inst_valid asserted while fb_stall high");

endmodule

bind front front_sva u_front_sva
(
    .cpu_clk           (cpu_clk),
    .arst_n            (arst_n),
    .fb_valid          (fb_valid),
    .fb_flush          (fb_flush),
    .bpu_flush         (bpu_flush),
    .icache_inst_valid (icache_inst_valid),
    .fb_stall          (fb_stall)
);

`default_nettype wire

// File: testbench/front_tb.sv
`timescale 1ns/1ps
`default_nettype none

module front_tb;

    localparam int unsigned SEED = 32'hf554_7ba1;
    localparam logic [31:0] BOOT = front_pkg::PC_RESET;
    localparam logic [31:0] X_PC = 32'h1c00_1000;       // trained branch
    localparam logic [31:0] T_PC = 32'h1c00_2000;       // its target
    localparam logic [31:0] B_PC = 32'h1c00_3000;       // mispredicted branch
    localparam front_pkg::ex_branch_t NO_BR = '0;

    typedef struct packed {
        front_pkg::ex_branch_t ex1;
        front_pkg::ex_branch_t ex2;
        logic [1:0]            flush;
        logic [1:0]            pause;
        logic [31:0]           new_pc;
        logic                  wr;                    // cache delivers a pair
        logic                  get;
        logic [31:0]           exp_pc;
        logic                  exp_bflush;
        logic [1:0]            exp_valid;
        logic                  exp_exc;
    } row_t;

    logic                    cpu_clk;
    logic                    arst_n;
    logic [31:0]             pi_pc;
    logic                    pi_is_exception;
    front_pkg::exc_cause_t   pi_exception_cause;
    logic                    inst_rreq_to_icache;
    logic                    bpu_flush;
    logic [31:0]             bpu_pred_addr;
    logic                    icache_inst_valid;
    front_pkg::fetch_entry_t icache_entry1;
    front_pkg::fetch_entry_t icache_entry2;
    logic                    icache_pc_suspend;
    front_pkg::fetch_entry_t fb_entry1;
    front_pkg::fetch_entry_t fb_entry2;
    logic [1:0]              fb_valid;
    logic                    fb_stall;
    logic                    get_data_req;
    front_pkg::ex_branch_t   ex_branch1;
    front_pkg::ex_branch_t   ex_branch2;
    logic [1:0]              fb_flush;
    logic [1:0]              fb_pause;
    logic [31:0]             fb_new_pc;

    row_t                    rows [$];
    front_pkg::fetch_entry_t model [$];                // expected buffer contents
    front_pkg::fetch_entry_t pend1;
    front_pkg::fetch_entry_t pend2;
    front_pkg::ex_branch_t   br_train;
    front_pkg::ex_branch_t   br_miss;
    int                      errors;
    int                      cycles;

    front DUT (.*);

    initial
    begin
        cpu_clk = 1'b0;
        forever #5 cpu_clk = ~cpu_clk;
    end

    function automatic front_pkg::fetch_entry_t make_entry(input logic [31:0] pc);
        front_pkg::fetch_entry_t e;
        e.pred_addr    = pc + 32'd8;
        e.pc           = pc;
        e.inst         = $urandom();
        e.is_exception = 1'b0;
        e.cause        = front_pkg::EXC_NONE;
        return e;
    endfunction

    function automatic front_pkg::ex_branch_t make_branch(input logic [31:0] pc,
                                                          input logic taken,
                                                          input logic [31:0] real_addr,
                                                          input logic [31:0] pred_addr);
        front_pkg::ex_branch_t b;
        b.valid      = 1'b1;
        b.is_bj      = 1'b1;
        b.pc         = pc;
        b.real_taken = taken;
        b.real_addr  = real_addr;
        b.pred_addr  = pred_addr;
        return b;
    endfunction

    task automatic add_row(input front_pkg::ex_branch_t b1, input logic [1:0] fl,
                           input logic [1:0] pa, input logic [31:0] npc, input logic wr,
                           input logic get, input logic [31:0] pc, input logic bf,
                           input logic [1:0] v, input logic exc);
        row_t r;
        r.ex1        = b1;
        r.ex2        = NO_BR;
        r.flush      = fl;
        r.pause      = pa;
        r.new_pc     = npc;
        r.wr         = wr;
        r.get        = get;
        r.exp_pc     = pc;
        r.exp_bflush = bf;
        r.exp_valid  = v;
        r.exp_exc    = exc;
        rows.push_back(r);
    endtask

    // ********************
    // stimulus table
    // ********************
    task automatic build_table();
        br_train = make_branch(X_PC, 1'b1, T_PC, T_PC);
        br_miss  = make_branch(B_PC, 1'b0, B_PC + 32'h400, B_PC + 32'h400);  // actual is pc+4
        // ex1    flush  pause  new_pc        wr    get   exp_pc          bflush valid exc
        add_row(NO_BR, 2'b00, 2'b00, 32'h0, 1'b0, 1'b0, BOOT, 1'b0, 2'b00, 1'b0);
        add_row(NO_BR, 2'b00, 2'b00, 32'h0, 1'b0, 1'b0, BOOT + 32'h08, 1'b0, 2'b00, 1'b0);
        add_row(NO_BR, 2'b00, 2'b01, 32'h0, 1'b0, 1'b0, BOOT + 32'h10, 1'b0, 2'b00, 1'b0);
        add_row(NO_BR, 2'b00, 2'b01, 32'h0, 1'b0, 1'b0, BOOT + 32'h10, 1'b0, 2'b00, 1'b0);
        add_row(NO_BR, 2'b00, 2'b00, 32'h0, 1'b0, 1'b0, BOOT + 32'h10, 1'b0, 2'b00, 1'b0);
        add_row(NO_BR, 2'b00, 2'b00, 32'h0, 1'b0, 1'b0, BOOT + 32'h18, 1'b0, 2'b00, 1'b0);
        add_row(NO_BR, 2'b00, 2'b00, 32'h0, 1'b1, 1'b0, BOOT + 32'h20, 1'b0, 2'b00, 1'b0);
        add_row(NO_BR, 2'b00, 2'b00, 32'h0, 1'b1, 1'b1, BOOT + 32'h28, 1'b0, 2'b11, 1'b0);
        add_row(NO_BR, 2'b00, 2'b00, 32'h0, 1'b0, 1'b1, BOOT + 32'h30, 1'b0, 2'b11, 1'b0);
        add_row(NO_BR, 2'b00, 2'b00, 32'h0, 1'b0, 1'b0, BOOT + 32'h38, 1'b0, 2'b00, 1'b0);
        // fill the queue until it stalls
        add_row(NO_BR, 2'b00, 2'b00, 32'h0, 1'b1, 1'b0, BOOT + 32'h40, 1'b0, 2'b00, 1'b0);
        add_row(NO_BR, 2'b00, 2'b00, 32'h0, 1'b1, 1'b0, BOOT + 32'h48, 1'b0, 2'b11, 1'b0);
        add_row(NO_BR, 2'b00, 2'b00, 32'h0, 1'b1, 1'b0, BOOT + 32'h50, 1'b0, 2'b11, 1'b0);
        add_row(NO_BR, 2'b00, 2'b00, 32'h0, 1'b1, 1'b0, BOOT + 32'h58, 1'b0, 2'b11, 1'b0);
        add_row(NO_BR, 2'b00, 2'b00, 32'h0, 1'b0, 1'b0, BOOT + 32'h60, 1'b0, 2'b11, 1'b0);
        add_row(NO_BR, 2'b00, 2'b00, 32'h0, 1'b0, 1'b0, BOOT + 32'h60, 1'b0, 2'b11, 1'b0);
        add_row(NO_BR, 2'b00, 2'b00, 32'h0, 1'b0, 1'b1, BOOT + 32'h60, 1'b0, 2'b11, 1'b0);
        add_row(NO_BR, 2'b00, 2'b00, 32'h0, 1'b0, 1'b0, BOOT + 32'h60, 1'b0, 2'b11, 1'b0);
        add_row(NO_BR, 2'b00, 2'b00, 32'h0, 1'b0, 1'b1, BOOT + 32'h68, 1'b0, 2'b11, 1'b0);
        add_row(NO_BR, 2'b00, 2'b00, 32'h0, 1'b0, 1'b1, BOOT + 32'h70, 1'b0, 2'b11, 1'b0);
        add_row(NO_BR, 2'b00, 2'b00, 32'h0, 1'b0, 1'b1, BOOT + 32'h78, 1'b0, 2'b11, 1'b0);
        add_row(NO_BR, 2'b00, 2'b00, 32'h0, 1'b0, 1'b0, BOOT + 32'h80, 1'b0, 2'b00, 1'b0);
        // train X -> T twice, then jump to X
        add_row(br_train, 2'b00, 2'b00, 32'h0, 1'b0, 1'b0, BOOT + 32'h88, 1'b0, 2'b00, 1'b0);
        add_row(br_train, 2'b00, 2'b00, 32'h0, 1'b0, 1'b0, BOOT + 32'h90, 1'b0, 2'b00, 1'b0);
        add_row(NO_BR, 2'b01, 2'b00, X_PC, 1'b0, 1'b0, BOOT + 32'h98, 1'b0, 2'b00, 1'b0);
        add_row(NO_BR, 2'b00, 2'b00, 32'h0, 1'b0, 1'b0, X_PC, 1'b0, 2'b00, 1'b0);
        add_row(NO_BR, 2'b00, 2'b00, 32'h0, 1'b0, 1'b0, T_PC, 1'b0, 2'b00, 1'b0);
        add_row(NO_BR, 2'b00, 2'b00, 32'h0, 1'b1, 1'b0, T_PC + 32'h08, 1'b0, 2'b00, 1'b0);
        add_row(br_miss, 2'b00, 2'b00, 32'h0, 1'b1, 1'b0, T_PC + 32'h10, 1'b1, 2'b11, 1'b0);
        add_row(NO_BR, 2'b00, 2'b00, 32'h0, 1'b0, 1'b0, B_PC + 32'h04, 1'b0, 2'b00, 1'b0);
        add_row(NO_BR, 2'b00, 2'b00, 32'h0, 1'b0, 1'b0, B_PC + 32'h0c, 1'b0, 2'b00, 1'b0);
        // misaligned redirect
        add_row(NO_BR, 2'b01, 2'b00, 32'h1c00_4002, 1'b0, 1'b0, B_PC + 32'h14, 1'b0, 2'b00, 1'b0);
        add_row(NO_BR, 2'b00, 2'b00, 32'h0, 1'b0, 1'b0, 32'h1c00_4002, 1'b0, 2'b00, 1'b1);
        add_row(NO_BR, 2'b01, 2'b00, 32'h1c00_5000, 1'b0, 1'b0, 32'h1c00_400a, 1'b0, 2'b00, 1'b1);
        add_row(NO_BR, 2'b00, 2'b00, 32'h0, 1'b0, 1'b0, 32'h1c00_5000, 1'b0, 2'b00, 1'b0);
    endtask

    task automatic drive_row(input row_t r);
        pend1 = make_entry(r.exp_pc);
        pend2 = make_entry(r.exp_pc + 32'd4);
        ex_branch1        <= r.ex1;
        ex_branch2        <= r.ex2;
        fb_flush          <= r.flush;
        fb_pause          <= r.pause;
        fb_new_pc         <= r.new_pc;
        icache_inst_valid <= r.wr;
        icache_entry1     <= pend1;
        icache_entry2     <= pend2;
        get_data_req      <= r.get;
    endtask

    task automatic mismatch(input string name, input string expv, input string gotv);
        errors++;
        $display("** Error at %0t: %s expected %s, got %s", $time, name, expv, gotv);
    endtask

    // ********************
    // checks and queue model
    // ********************
    task automatic check_row(input row_t r);
        logic                  exp_stall;
        front_pkg::exc_cause_t exp_cause;
        logic [31:0]           exp_pred;
        exp_stall = model.size() > front_pkg::IB_DEPTH - 2;   // fewer than two free
        exp_cause = r.exp_exc ? front_pkg::EXC_ADEF : front_pkg::EXC_NONE;
        exp_pred  = (r.exp_pc == X_PC) ? T_PC : r.exp_pc + 32'd8;  // only X trained taken
        if (pi_pc !== r.exp_pc)
            mismatch("pi_pc", $sformatf("%h", r.exp_pc), $sformatf("%h", pi_pc));
        if (bpu_flush !== r.exp_bflush)
            mismatch("bpu_flush", $sformatf("%b", r.exp_bflush), $sformatf("%b", bpu_flush));
        if (bpu_pred_addr !== exp_pred)
            mismatch("bpu_pred_addr", $sformatf("%h", exp_pred),
                     $sformatf("%h", bpu_pred_addr));
        if (fb_valid !== r.exp_valid)
            mismatch("fb_valid", $sformatf("%b", r.exp_valid), $sformatf("%b", fb_valid));
        if (fb_stall !== exp_stall)
            mismatch("fb_stall", $sformatf("%b", exp_stall), $sformatf("%b", fb_stall));
        if (inst_rreq_to_icache !== !(r.pause[0] || exp_stall))
            mismatch("inst_rreq_to_icache", $sformatf("%b", !(r.pause[0] || exp_stall)),
                     $sformatf("%b", inst_rreq_to_icache));
        if (pi_is_exception !== r.exp_exc)
            mismatch("pi_is_exception", $sformatf("%b", r.exp_exc),
                     $sformatf("%b", pi_is_exception));
        if (pi_exception_cause !== exp_cause)
            mismatch("pi_exception_cause", $sformatf("%h", exp_cause),
                     $sformatf("%h", pi_exception_cause));
        if (model.size() > 0 && fb_entry1 !== model[0])
            mismatch("fb_entry1", $sformatf("%h", model[0]), $sformatf("%h", fb_entry1));
        if (model.size() > 1 && fb_entry2 !== model[1])
            mismatch("fb_entry2", $sformatf("%h", model[1]), $sformatf("%h", fb_entry2));
    endtask

    task automatic update_model(input row_t r);
        int n;
        n = (model.size() > 1) ? 2 : model.size();
        if (r.flush[1] || r.exp_bflush)
        begin
            model.delete();                            // write in the same cycle is lost
        end
        else
        begin
            if (r.get)
            begin
                for (int k = 0; k < n; k++)
                    model.delete(0);
            end
            if (r.wr)
            begin
                model.push_back(pend1);
                model.push_back(pend2);
            end
        end
    endtask

    initial
    begin
        void'($urandom(SEED));
        errors = 0;
        build_table();
        arst_n            = 1'b0;
        icache_inst_valid = 1'b0;
        icache_entry1     = '0;
        icache_entry2     = '0;
        icache_pc_suspend = 1'b0;
        get_data_req      = 1'b0;
        ex_branch1        = NO_BR;
        ex_branch2        = NO_BR;
        fb_flush          = 2'b00;
        fb_pause          = 2'b00;
        fb_new_pc         = 32'h0;
        repeat (4) @(posedge cpu_clk);
        arst_n <= 1'b1;                                // first row starts on this edge
        for (int i = 0; i < rows.size(); i++)
        begin
            drive_row(rows[i]);
            @(negedge cpu_clk);
            check_row(rows[i]);
            update_model(rows[i]);
            @(posedge cpu_clk);
        end
        $display("Checked %0d rows, %0d errors", rows.size(), errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    // run length guard
    initial
    begin
        int limit;
        cycles = 0;
        @(posedge cpu_clk);
        limit = 2 * rows.size() + 50;
        while (cycles < limit)
        begin
            @(posedge cpu_clk);
            cycles++;
        end
        $display("Timeout: run still active after %0d cycles", limit);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module branch_predictor
(
    input  wire                     cpu_clk,
    input  wire                     arst_n,
    input  wire [31:0]              if_pc,
    input  wire front_pkg::ex_branch_t ex_branch1,
    input  wire front_pkg::ex_branch_t ex_branch2,
    output logic                    pred_taken,
    output logic [31:0]             pred_addr,
    output logic                    bpu_flush,
    output logic [31:0]             new_pc
);

    logic                              btb_valid  [front_pkg::BTB_ENTRIES];
    logic [front_pkg::BTB_TAG_W-1:0]   btb_tag    [front_pkg::BTB_ENTRIES];
    logic [31:0]                       btb_target [front_pkg::BTB_ENTRIES];
    front_pkg::bht_state_t             btb_cnt    [front_pkg::BTB_ENTRIES];

    front_pkg::ex_branch_t             ex_slot    [2];
    logic [31:0]                       look_pc    [2];
    logic [front_pkg::BTB_IDX_W-1:0]   look_idx   [2];
    logic                              slot_taken [2];
    logic [31:0]                       act_next   [2];
    logic                              mispredict [2];
    logic                              train      [2];
    logic [front_pkg::BTB_IDX_W-1:0]   train_idx  [2];
    logic [front_pkg::BTB_TAG_W-1:0]   train_tag  [2];
    front_pkg::bht_state_t             cnt_next   [2];

    // saturating 2-bit counter step
    function automatic front_pkg::bht_state_t step_cnt(front_pkg::bht_state_t cur,
                                                      logic taken);
        case (cur)
            front_pkg::STRONG_NT: step_cnt = taken ? front_pkg::WEAK_NT  : front_pkg::STRONG_NT;
            front_pkg::WEAK_NT:   step_cnt = taken ? front_pkg::WEAK_T   : front_pkg::STRONG_NT;
            front_pkg::WEAK_T:    step_cnt = taken ? front_pkg::STRONG_T : front_pkg::WEAK_NT;
            default:              step_cnt = taken ? front_pkg::STRONG_T : front_pkg::WEAK_T;
        endcase
    endfunction

    assign ex_slot[0] = ex_branch1;
    assign ex_slot[1] = ex_branch2;
    assign look_pc[0] = if_pc;
    assign look_pc[1] = if_pc + front_pkg::INST_BYTES;

    // ********************
    // lookup and resolve
    // ********************
    always_comb
    begin
        for (int s = 0; s < 2; s++)
        begin
            look_idx[s]   = look_pc[s][front_pkg::BTB_IDX_W+1:2];
            slot_taken[s] = btb_valid[look_idx[s]]
                          && (btb_tag[look_idx[s]] == look_pc[s][31:front_pkg::BTB_IDX_W+2])
                          && btb_cnt[look_idx[s]][1];           // WEAK_T or STRONG_T
            act_next[s]   = ex_slot[s].real_taken ? ex_slot[s].real_addr
                                                  : ex_slot[s].pc + front_pkg::INST_BYTES;
            mispredict[s] = ex_slot[s].valid && ex_slot[s].is_bj
                          && (ex_slot[s].pred_addr != act_next[s]);
            train_idx[s]  = ex_slot[s].pc[front_pkg::BTB_IDX_W+1:2];
            train_tag[s]  = ex_slot[s].pc[31:front_pkg::BTB_IDX_W+2];
            // new or replaced entry counts from WEAK_NT
            if (btb_valid[train_idx[s]] && (btb_tag[train_idx[s]] == train_tag[s]))
                cnt_next[s] = step_cnt(btb_cnt[train_idx[s]], ex_slot[s].real_taken);
            else
                cnt_next[s] = step_cnt(front_pkg::WEAK_NT, ex_slot[s].real_taken);
        end
        train[0] = ex_slot[0].valid && ex_slot[0].is_bj;
        train[1] = ex_slot[1].valid && ex_slot[1].is_bj && !mispredict[0];  // wrong path
    end

    assign pred_taken = slot_taken[0] | slot_taken[1];
    assign pred_addr  = slot_taken[0] ? btb_target[look_idx[0]] :
                        slot_taken[1] ? btb_target[look_idx[1]] :
                                        if_pc + front_pkg::FETCH_BYTES;
    assign bpu_flush  = mispredict[0] | mispredict[1];
    assign new_pc     = mispredict[0] ? act_next[0] : act_next[1];  // older slot first

    // ********************
    // training
    // ********************
    always_ff @(posedge cpu_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < front_pkg::BTB_ENTRIES; i++)
            begin
                btb_valid[i] <= 1'b0;
                btb_cnt[i]   <= front_pkg::WEAK_NT;
            end
        end
        else
        begin
            for (int s = 0; s < 2; s++)
            begin
                if (train[s])
                begin
                    btb_valid[train_idx[s]] <= 1'b1;
                    btb_cnt[train_idx[s]]   <= cnt_next[s];   // slot 2 wins on same index
                end
            end
        end
    end

    always_ff @(posedge cpu_clk)
    begin
        for (int s = 0; s < 2; s++)
        begin
            if (train[s])
            begin
                btb_tag[train_idx[s]] <= train_tag[s];
                if (ex_slot[s].real_taken)
                    btb_target[train_idx[s]] <= ex_slot[s].real_addr;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/front.sv
`timescale 1ns/1ps
`default_nettype none

module front
(
    input  wire                          cpu_clk,
    input  wire                          arst_n,

    // icache side
    output logic [31:0]                  pi_pc,
    output logic                         pi_is_exception,
    output front_pkg::exc_cause_t        pi_exception_cause,
    output logic                         inst_rreq_to_icache,
    output logic                         bpu_flush,
    output logic [31:0]                  bpu_pred_addr,
    input  wire                          icache_inst_valid,
    input  wire front_pkg::fetch_entry_t icache_entry1,
    input  wire front_pkg::fetch_entry_t icache_entry2,
    input  wire                          icache_pc_suspend,

    // backend side
    output front_pkg::fetch_entry_t      fb_entry1,
    output front_pkg::fetch_entry_t      fb_entry2,
    output logic [1:0]                   fb_valid,
    output logic                         fb_stall,
    input  wire                          get_data_req,
    input  wire front_pkg::ex_branch_t   ex_branch1,
    input  wire front_pkg::ex_branch_t   ex_branch2,
    input  wire [1:0]                    fb_flush,   // [0] pc redirect, [1] buffer flush
    input  wire [1:0]                    fb_pause,   // [0] fetch hold, [1] decode hold
    input  wire [31:0]                   fb_new_pc
);

    logic        pred_taken;
    logic [31:0] bpu_new_pc;

    pc_gen u_pc_gen
    (
        .cpu_clk         (cpu_clk),
        .arst_n          (arst_n),
        .pause           (fb_pause[0] | icache_pc_suspend | fb_stall),
        .bpu_flush       (bpu_flush),
        .bpu_new_pc      (bpu_new_pc),
        .fb_flush0       (fb_flush[0]),
        .fb_new_pc       (fb_new_pc),
        .pred_taken      (pred_taken),
        .pred_addr       (bpu_pred_addr),
        .pc_out          (pi_pc),
        .pc_is_exception (pi_is_exception),
        .pc_cause        (pi_exception_cause),
        .fetch_req       (inst_rreq_to_icache)
    );

    branch_predictor u_branch_predictor
    (
        .cpu_clk    (cpu_clk),
        .arst_n     (arst_n),
        .if_pc      (pi_pc),                // lookup on the live fetch pc
        .ex_branch1 (ex_branch1),
        .ex_branch2 (ex_branch2),
        .pred_taken (pred_taken),
        .pred_addr  (bpu_pred_addr),
        .bpu_flush  (bpu_flush),
        .new_pc     (bpu_new_pc)
    );

    inst_buffer u_inst_buffer
    (
        .cpu_clk      (cpu_clk),
        .arst_n       (arst_n),
        .flush        (fb_flush[1] | bpu_flush),
        .inst_valid   (icache_inst_valid),
        .entry_in1    (icache_entry1),
        .entry_in2    (icache_entry2),
        .get_data_req (get_data_req & ~fb_pause[1]),  // decode hold blocks the read
        .entry_out1   (fb_entry1),
        .entry_out2   (fb_entry2),
        .data_valid   (fb_valid),
        .stall        (fb_stall)
    );

endmodule

`default_nettype wire

// File: verilog/front_pkg.sv
`default_nettype none

package front_pkg;

    // ********************
    // sizes and constants
    // ********************
    localparam logic [31:0] PC_RESET    = 32'h1c00_0000;   // boot address
    localparam logic [31:0] FETCH_BYTES = 32'd8;           // two insts per fetch
    localparam logic [31:0] INST_BYTES  = 32'd4;

    localparam int BTB_ENTRIES = 16;
    localparam int BTB_IDX_W   = $clog2(BTB_ENTRIES);     // pc[5:2]
    localparam int BTB_TAG_W   = 32 - 2 - BTB_IDX_W;      // pc[31:6]

    localparam int IB_DEPTH = 8;
    localparam int IB_PTR_W = $clog2(IB_DEPTH);
    localparam int IB_CNT_W = IB_PTR_W + 1;               // holds 0..IB_DEPTH

    // ********************
    // encodings
    // ********************
    typedef enum logic [6:0] {
        EXC_ADEF = 7'h08,                                  // fetch address error
        EXC_NONE = 7'h7f                                   // no exception
    } exc_cause_t;

    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } bht_state_t;

    // one fetched instruction as it travels through the buffer
    typedef struct packed {
        logic [31:0] pred_addr;                            // predicted next fetch pc
        logic [31:0] pc;
        logic [31:0] inst;
        logic        is_exception;
        exc_cause_t  cause;
    } fetch_entry_t;

    // branch outcome reported back from execute
    typedef struct packed {
        logic        valid;
        logic        is_bj;                                // branch or jump
        logic [31:0] pc;
        logic        real_taken;
        logic [31:0] real_addr;
        logic [31:0] pred_addr;
    } ex_branch_t;

endpackage

`default_nettype wire

// File: verilog/inst_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module inst_buffer
(
    input  wire                          cpu_clk,
    input  wire                          arst_n,
    input  wire                          flush,
    input  wire                          inst_valid,     // cache delivers a pair
    input  wire front_pkg::fetch_entry_t entry_in1,
    input  wire front_pkg::fetch_entry_t entry_in2,
    input  wire                          get_data_req,   // backend takes data_valid entries
    output front_pkg::fetch_entry_t      entry_out1,
    output front_pkg::fetch_entry_t      entry_out2,
    output logic [1:0]                   data_valid,
    output logic                         stall
);

    front_pkg::fetch_entry_t          ib_mem [front_pkg::IB_DEPTH];

    logic [front_pkg::IB_PTR_W-1:0]   wr_ptr;
    logic [front_pkg::IB_PTR_W-1:0]   rd_ptr;
    logic [front_pkg::IB_PTR_W-1:0]   rd_ptr_p1;
    logic [front_pkg::IB_PTR_W-1:0]   wr_ptr_p1;
    logic [front_pkg::IB_CNT_W-1:0]   count;
    logic                             wr_en;
    logic [1:0]                       rd_num;

    // ********************
    // status
    // ********************
    assign stall      = count > front_pkg::IB_CNT_W'(front_pkg::IB_DEPTH - 2);  // < 2 free
    assign data_valid = {count >= front_pkg::IB_CNT_W'(2), count != '0};

    // a pair is only taken with room for both, and never during flush
    assign wr_en  = inst_valid & ~stall & ~flush;
    assign rd_num = !get_data_req ? 2'd0 :
                    data_valid[1] ? 2'd2 : {1'b0, data_valid[0]};

    assign rd_ptr_p1 = rd_ptr + front_pkg::IB_PTR_W'(1);
    assign wr_ptr_p1 = wr_ptr + front_pkg::IB_PTR_W'(1);

    // asynchronous read of the two oldest slots
    assign entry_out1 = ib_mem[rd_ptr];
    assign entry_out2 = ib_mem[rd_ptr_p1];

    // ********************
    // pointers and count
    // ********************
    always_ff @(posedge cpu_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else if (flush)
        begin
            wr_ptr <= '0;                              // drop everything
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= wr_ptr + front_pkg::IB_PTR_W'(2);
            rd_ptr <= rd_ptr + front_pkg::IB_PTR_W'(rd_num);
            count  <= count + front_pkg::IB_CNT_W'({wr_en, 1'b0})
                            - front_pkg::IB_CNT_W'(rd_num);
        end
    end

    // ********************
    // storage
    // ********************
    always_ff @(posedge cpu_clk)
    begin
        if (wr_en)
        begin
            ib_mem[wr_ptr]    <= entry_in1;             // older inst first
            ib_mem[wr_ptr_p1] <= entry_in2;
        end
    end

endmodule

`default_nettype wire

// File: verilog/pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

module pc_gen
(
    input  wire                    cpu_clk,
    input  wire                    arst_n,
    input  wire                    pause,         // hold the fetch pc
    input  wire                    bpu_flush,     // mispredict from execute
    input  wire [31:0]             bpu_new_pc,
    input  wire                    fb_flush0,     // backend redirect
    input  wire [31:0]             fb_new_pc,
    input  wire                    pred_taken,
    input  wire [31:0]             pred_addr,
    output logic [31:0]            pc_out,
    output logic                   pc_is_exception,
    output front_pkg::exc_cause_t  pc_cause,
    output logic                   fetch_req
);

    logic [31:0] pc_next;

    // ********************
    // next pc selection
    // ********************
    always_comb
    begin
        if (bpu_flush)
        begin
            pc_next = bpu_new_pc;                     // mispredict wins
        end
        else if (fb_flush0)
        begin
            pc_next = fb_new_pc;
        end
        else if (pause)
        begin
            pc_next = pc_out;                         // hold
        end
        else if (pred_taken)
        begin
            pc_next = pred_addr;
        end
        else
        begin
            pc_next = pc_out + front_pkg::FETCH_BYTES;
        end
    end

    always_ff @(posedge cpu_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pc_out <= front_pkg::PC_RESET;
        end
        else
        begin
            pc_out <= pc_next;
        end
    end

    // word alignment check on the current fetch address
    assign pc_is_exception = |pc_out[1:0];
    assign pc_cause        = pc_is_exception ? front_pkg::EXC_ADEF : front_pkg::EXC_NONE;
    assign fetch_req       = ~pause;

endmodule

`default_nettype wire
